//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // architectural word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the kept instruction groups
  typedef enum logic [6:0] {
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_lui     = 7'b0110111,
    op_branch  = 7'b1100011,
    op_environ = 7'b1110011
  } opcode_e;

  // operation selected for the ALU
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui result is the U immediate itself
    alu_pass_imm
  } alu_op_e;

  // branch conditions carry their funct3 encoding
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_cond_e;

  // everything downstream needs from one instruction word
  typedef struct packed {
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    // I, U (already shifted) or B immediate, sign extended
    word_t        imm;
    alu_op_e      alu_op;
    logic         use_imm;
    // low for x0 and for anything not recognized
    logic         writes_rd;
    logic         is_branch;
    branch_cond_e branch_cond;
    logic         is_halt;
  } decoded_insn_t;

  // register write made by the current instruction
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

`default_nettype wire

//--- src/insn_decoder.sv
`default_nettype none

module insn_decoder (
  input  rv_pkg::word_t         insn,
  output rv_pkg::decoded_insn_t dec
);
  import rv_pkg::*;

  // instruction fields, R-type layout
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;

  // immediates in their final, sign-extended form
  word_t imm_i;
  word_t imm_u;
  word_t imm_b;

  // set when the word is one of the kept ALU or lui instructions
  logic legal_alu;

  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = rd;
    dec.rs1    = rs1;
    dec.rs2    = rs2;
    dec.alu_op = alu_add;
    legal_alu  = 1'b0;

    case (opcode)
      op_reg_imm: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        legal_alu   = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          3'b001: begin
            dec.alu_op = alu_sll;
            legal_alu  = (funct7 == 7'b0000000);
          end
          default: begin
            // funct7 picks logical or arithmetic right shift
            dec.alu_op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
            legal_alu  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end

      op_reg_reg: begin
        legal_alu = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = alu_add;
          10'b0100000_000: dec.alu_op = alu_sub;
          10'b0000000_001: dec.alu_op = alu_sll;
          10'b0000000_010: dec.alu_op = alu_slt;
          10'b0000000_011: dec.alu_op = alu_sltu;
          10'b0000000_100: dec.alu_op = alu_xor;
          10'b0000000_101: dec.alu_op = alu_srl;
          10'b0100000_101: dec.alu_op = alu_sra;
          10'b0000000_110: dec.alu_op = alu_or;
          10'b0000000_111: dec.alu_op = alu_and;
          default:         legal_alu  = 1'b0;
        endcase
      end

      op_lui: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_imm;
        legal_alu   = 1'b1;
      end

      op_branch: begin
        dec.imm = imm_b;
        // funct3 010 and 011 are not branches
        if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111}) begin
          dec.is_branch   = 1'b1;
          dec.branch_cond = branch_cond_e'(funct3);
        end
      end

      op_environ: begin
        // only ecall, every other system word is a no-op
        dec.is_halt = (insn[31:7] == 25'd0);
      end

      default: ;
    endcase

    // x0 is never written, this is the only place that rule lives
    dec.writes_rd = legal_alu && (rd != 5'd0);
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);
  import rv_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  // x0 reads zero whatever the array holds
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  // the decoder drops writes to x0 before they reach this port
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (rst) !(we && rd == 5'd0)
  );

endmodule

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu (
  input  rv_pkg::decoded_insn_t dec,
  input  rv_pkg::word_t         rs1_data,
  input  rv_pkg::word_t         rs2_data,
  output rv_pkg::word_t         result,
  output logic                  taken
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  logic       equal;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  // comparators shared by slt, sltu and the branches
  // branches never set use_imm, so op_b is rs2 there
  assign equal       = (rs1_data == op_b);
  assign lt_signed   = ($signed(rs1_data) < $signed(op_b));
  assign lt_unsigned = (rs1_data < op_b);

  always_comb begin
    case (dec.alu_op)
      alu_add:      result = rs1_data + op_b;
      alu_sub:      result = rs1_data - op_b;
      alu_sll:      result = rs1_data << shamt;
      alu_slt:      result = {31'b0, lt_signed};
      alu_sltu:     result = {31'b0, lt_unsigned};
      alu_xor:      result = rs1_data ^ op_b;
      alu_srl:      result = rs1_data >> shamt;
      alu_sra:      result = word_t'($signed(rs1_data) >>> shamt);
      alu_or:       result = rs1_data | op_b;
      alu_and:      result = rs1_data & op_b;
      alu_pass_imm: result = dec.imm;
      default:      result = '0;
    endcase
  end

  always_comb begin
    case (dec.branch_cond)
      beq:     cond = equal;
      bne:     cond = !equal;
      blt:     cond = lt_signed;
      bge:     cond = !lt_signed;
      bltu:    cond = lt_unsigned;
      bgeu:    cond = !lt_unsigned;
      default: cond = 1'b0;
    endcase
  end

  assign taken = dec.is_branch && cond;

endmodule

`default_nettype wire

//--- src/pc_unit.sv
`default_nettype none

module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::decoded_insn_t dec,
  input  logic                  taken,
  output rv_pkg::word_t         pc,
  output logic                  halt
);
  import rv_pkg::*;

  word_t pc_plus4;
  word_t pc_target;
  word_t pc_next;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm;

  always_comb begin
    // an ecall parks the pc on itself
    if (halt || dec.is_halt) begin
      pc_next = pc;
    end else if (taken) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= RESET_PC;
      halt <= 1'b0;
    end else begin
      pc   <= pc_next;
      // sticky until the next reset
      halt <= halt || dec.is_halt;
    end
  end

  // branch targets from the decoder must keep word alignment
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

//--- src/rv_core.sv
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::word_t   pc,
  input  rv_pkg::word_t   insn,
  output logic            halt,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  decoded_insn_t dec;
  word_t         rs1_data;
  word_t         rs2_data;
  word_t         result;
  logic          taken;
  logic          we;

  // nothing is written once the core has halted
  assign we = dec.writes_rd && !halt;

  assign retire.valid = we && !rst;
  assign retire.rd    = dec.rd;
  assign retire.data  = result;

  insn_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (we),
    .rd       (dec.rd),
    .rd_data  (result)
  );

  alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result),
    .taken    (taken)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk   (clk),
    .rst   (rst),
    .dec   (dec),
    .taken (taken),
    .pc    (pc),
    .halt  (halt)
  );

endmodule

`default_nettype wire

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

`default_nettype none

// one RV32I step over the model state, pc and halted are updated in place
// returns the register write the instruction makes
function automatic rv_pkg::retire_t step_instruction(
  input rv_pkg::word_t     insn,
  inout rv_pkg::word_t     pc,
  inout logic [31:0][31:0] regs,
  inout logic              halted
);
  rv_pkg::retire_t ret;
  logic [31:0] a;
  logic [31:0] op2;
  logic [31:0] imm_b;
  logic [31:0] val;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        is_alu;
  logic        legal;
  logic        take;

  ret    = '0;
  val    = '0;
  is_alu = 1'b0;
  legal  = 1'b0;
  take   = 1'b0;
  rd     = insn[11:7];
  f3     = insn[14:12];
  f7     = insn[31:25];
  a      = regs[insn[19:15]];
  op2    = regs[insn[24:20]];
  imm_b  = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  if (halted) begin
    return ret;
  end

  case (insn[6:0])
    7'b0010011: begin
      is_alu = 1'b1;
      op2    = {{20{insn[31]}}, insn[31:20]};
      // shift forms only allow 0000000, or 0100000 for srai, above shamt
      legal  = (f3 == 3'd1) ? (f7 == 7'h00) :
               (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
    end
    7'b0110011: begin
      is_alu = 1'b1;
      legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    end
    7'b0110111: begin
      legal = 1'b1;
      val   = {insn[31:12], 12'b0};
    end
    7'b1100011: begin
      case (f3)
        3'd0:    take = (a == op2);
        3'd1:    take = (a != op2);
        3'd4:    take = ($signed(a) < $signed(op2));
        3'd5:    take = ($signed(a) >= $signed(op2));
        3'd6:    take = (a < op2);
        3'd7:    take = (a >= op2);
        default: take = 1'b0;
      endcase
    end
    7'b1110011: begin
      halted = (insn[31:7] == 25'd0);
    end
    default: ;
  endcase

  if (is_alu) begin
    case (f3)
      3'd0: begin
        // sub exists only in the register form
        if (insn[5] && f7[5]) begin
          val = a - op2;
        end else begin
          val = a + op2;
        end
      end
      3'd1: val = a << op2[4:0];
      3'd2: val = {31'b0, $signed(a) < $signed(op2)};
      3'd3: val = {31'b0, a < op2};
      3'd4: val = a ^ op2;
      3'd5: begin
        if (f7[5]) begin
          val = $signed(a) >>> op2[4:0];
        end else begin
          val = a >> op2[4:0];
        end
      end
      3'd6:    val = a | op2;
      default: val = a & op2;
    endcase
  end

  if (legal && rd != 5'd0) begin
    regs[rd]  = val;
    ret.valid = 1'b1;
    ret.rd    = rd;
    ret.data  = val;
  end
  // ecall leaves the pc where it is
  if (!halted) begin
    pc = take ? pc + imm_b : pc + 32'd4;
  end
  return ret;
endfunction

`default_nettype wire

`endif

//--- verification/rv_core_tb.sv
`include "rv_ref_model.svh"

`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  localparam word_t START_PC  = 32'h0000_0000;
  localparam int    MEM_WORDS = 256;
  localparam int    RAND_OPS  = 40;
  localparam int    HALT_HOLD = 10;

  logic    clk = 1'b0;
  logic    rst;
  word_t   pc;
  word_t   insn;
  logic    halt;
  retire_t retire;

  word_t imem [MEM_WORDS];
  int    prog_len;
  int    limit = 0;
  int    cycles;
  int    checks;
  int    errors;
  int    halted_cycles;
  logic  done;

  // reference state
  word_t             model_pc;
  logic [31:0][31:0] model_regs;
  logic              model_halt;
  retire_t           expected;

  always #50 clk = ~clk;

  // instruction memory answers combinationally
  assign insn = imem[pc[9:2]];

  rv_core #(
    .RESET_PC (START_PC)
  ) uut (
    .clk    (clk),
    .rst    (rst),
    .pc     (pc),
    .insn   (insn),
    .halt   (halt),
    .retire (retire)
  );

  function automatic word_t itype(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic word_t rtype(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t utype(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t btype(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic emit(input word_t word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    for (int i = 0; i < MEM_WORDS; i++) begin
      // opcode 1111111 tagged with the word address
      imem[i] = {i[24:0], 7'b1111111};
    end
    prog_len = 0;
    // nop keeps retire low in the first cycle after reset
    emit(itype(12'h000, 5'd0, 3'd0, 5'd0));
    emit(utype(20'h80000, 5'd1));
    emit(utype(20'h12345, 5'd2));
    emit(itype(12'h678, 5'd2, 3'd0, 5'd3));
    emit(itype(12'hffb, 5'd0, 3'd0, 5'd4));
    emit(itype(12'hffc, 5'd4, 3'd2, 5'd5));
    emit(itype(12'hffa, 5'd4, 3'd2, 5'd6));
    emit(itype(12'hfff, 5'd4, 3'd3, 5'd7));
    emit(itype(12'h005, 5'd3, 3'd3, 5'd8));
    emit(itype(12'hfff, 5'd3, 3'd4, 5'd9));
    emit(itype(12'h0f0, 5'd4, 3'd6, 5'd10));
    emit(itype(12'h7f0, 5'd3, 3'd7, 5'd11));
    emit(itype(12'h004, 5'd3, 3'd1, 5'd12));
    emit(itype(12'h01f, 5'd1, 3'd5, 5'd13));
    emit(itype(12'h401, 5'd4, 3'd5, 5'd14));
    emit(itype(12'h40c, 5'd1, 3'd5, 5'd15));
    emit(itype(12'h001, 5'd3, 3'd0, 5'd0));
    // random contents for x16 to x31
    for (int k = 16; k < 32; k++) begin
      emit(utype(20'($urandom()), 5'(k)));
      emit(itype(12'($urandom()), 5'(k), 3'd0, 5'(k)));
    end
    for (int k = 0; k < RAND_OPS; k++) begin
      f3 = 3'($urandom_range(7, 0));
      f7 = 7'h00;
      if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) begin
        f7 = 7'h20;
      end
      // every eighth one targets x0
      rd = (k % 8 == 7) ? 5'd0 : 5'($urandom_range(31, 0));
      emit(rtype(f7, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)), f3, rd));
    end
    // x1 = -3, x2 = x3 = 5
    emit(itype(12'hffd, 5'd0, 3'd0, 5'd1));
    emit(itype(12'h005, 5'd0, 3'd0, 5'd2));
    emit(itype(12'h005, 5'd0, 3'd0, 5'd3));
    // operand pairs that are equal, signed less or unsigned less
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit(btype(13'd8, 5'(3 - p), (p == 1) ? 5'd1 : 5'd2, 3'(c < 2 ? c : c + 2)));
        emit(itype(12'h001, 5'd4, 3'd0, 5'd4));
      end
    end
    // mul and opcode 1111111 are not recognized
    emit(rtype(7'h01, 5'd2, 5'd3, 3'd0, 5'd5));
    emit(32'hffff_ffff);
    emit(32'h0000_0073);
    limit = 4 * prog_len + 50;
  endtask

  initial begin
    void'($urandom(44));
    rst           = 1'b1;
    checks        = 0;
    errors        = 0;
    halted_cycles = 0;
    done          = 1'b0;
    model_pc      = START_PC;
    model_regs    = '0;
    model_halt    = 1'b0;
    build_program();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // sampled halfway between rising edges
  always @(negedge clk) begin
    if (rst) begin
      checks++;
      assert (pc == START_PC && !halt && !retire.valid) else begin
        errors++;
        $display("Error at %0t: in reset pc %h halt %b valid %b", $time, pc, halt,
                 retire.valid);
      end
    end else if (!done) begin
      checks += 2;
      assert (pc == model_pc && halt == model_halt) else begin
        errors++;
        $display("Error at %0t: pc %h halt %b, expected pc %h halt %b", $time, pc, halt,
                 model_pc, model_halt);
      end
      expected = step_instruction(imem[model_pc[9:2]], model_pc, model_regs, model_halt);
      assert (retire.valid == expected.valid && (!expected.valid ||
              (retire.rd == expected.rd && retire.data == expected.data))) else begin
        errors++;
        $display("Error at %0t: retire %b x%0d %h, expected %b x%0d %h", $time,
                 retire.valid, retire.rd, retire.data, expected.valid, expected.rd,
                 expected.data);
      end
      if (model_halt) begin
        halted_cycles++;
      end
      // only the sticky halt keeps this word under the parked pc from retiring
      if (halted_cycles == 2) begin
        imem[model_pc[9:2]] = itype(12'h001, 5'd0, 3'd0, 5'd5);
      end
      if (halted_cycles > HALT_HOLD) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verification
src/rv_pkg.sv
src/insn_decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/rv_core.sv
verification/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +%,$(shell cat files.f))
HEADERS := verification/rv_ref_model.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): files.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
